// File: common/dmix_pkg.sv
package dmix_pkg;

    // Audio sample format
    localparam int SAMPLE_W = 24;

    // Frame buffer sizing
    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W = 3;

    // Credit counter must hold FIFO_DEPTH itself
    localparam int CREDIT_W = 4;

    // I2S timing in clk245760 cycles
    localparam int FRAME_CLKS = 256;
    localparam int BCK_DIV = 4;

    // Bit slots per channel half, 64 per frame
    localparam int SLOT_BITS = 32;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

endpackage

// File: logic/dai_sample_pairer.sv
`timescale 1ns/1ps

module dai_sample_pairer (
    input  logic              clk245760,
    input  logic              rst,

    input  dmix_pkg::sample_t smp_data_i,
    input  logic              smp_lrck_i,
    input  logic              smp_ack_i,

    input  logic              credit_i,
    output logic              push_o,
    output dmix_pkg::sample_t push_left_o,
    output dmix_pkg::sample_t push_right_o,

    output logic              sync_err_o,
    output logic              overflow_o
);

    localparam logic [dmix_pkg::CREDIT_W-1:0] CREDIT_INIT =
        dmix_pkg::CREDIT_W'(dmix_pkg::FIFO_DEPTH);

    dmix_pkg::sample_t             held_left;
    logic                          held_valid;
    logic [dmix_pkg::CREDIT_W-1:0] credit_cnt;

    logic left_in;
    logic right_in;
    logic pair_done;
    logic push_take;

    assign left_in   = smp_ack_i & smp_lrck_i;
    assign right_in  = smp_ack_i & ~smp_lrck_i;
    assign pair_done = right_in & held_valid;
    // A pair only goes out if a credit is on hand
    assign push_take = pair_done & (credit_cnt != '0);

    // Pending left sample
    always_ff @(posedge clk245760) begin
        if (rst) begin
            held_valid <= 1'b0;
        end else if (left_in) begin
            held_valid <= 1'b1;
        end else if (right_in) begin
            held_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk245760) begin
        if (left_in) begin
            held_left <= smp_data_i;
        end
    end

    // Ordering errors and dropped pairs
    always_ff @(posedge clk245760) begin
        if (rst) begin
            sync_err_o <= 1'b0;
            overflow_o <= 1'b0;
        end else begin
            sync_err_o <= (left_in & held_valid) | (right_in & ~held_valid);
            overflow_o <= pair_done & (credit_cnt == '0);
        end
    end

    always_ff @(posedge clk245760) begin
        if (rst) begin
            push_o <= 1'b0;
        end else begin
            push_o <= push_take;
        end
    end

    always_ff @(posedge clk245760) begin
        if (push_take) begin
            push_left_o  <= held_left;
            push_right_o <= smp_data_i;
        end
    end

    // A push spends a credit and a credit pulse returns one
    always_ff @(posedge clk245760) begin
        if (rst) begin
            credit_cnt <= CREDIT_INIT;
        end else if (push_take && !credit_i) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (credit_i && !push_take) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    // More credits than buffer slots means a stray credit pulse
    a_credit_bound: assert property (
        @(posedge clk245760) disable iff (rst)
        credit_cnt <= CREDIT_INIT
    );

endmodule

// File: logic/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo (
    input  logic              clk245760,
    input  logic              rst,

    input  logic              push_i,
    input  dmix_pkg::sample_t push_left_i,
    input  dmix_pkg::sample_t push_right_i,

    input  logic              pop_i,
    output logic              empty_o,
    output dmix_pkg::sample_t head_left_o,
    output dmix_pkg::sample_t head_right_o,

    output logic              credit_o
);

    localparam int CNT_W = dmix_pkg::PTR_W + 1;

    dmix_pkg::sample_t mem_left  [dmix_pkg::FIFO_DEPTH];
    dmix_pkg::sample_t mem_right [dmix_pkg::FIFO_DEPTH];

    logic [dmix_pkg::PTR_W-1:0] wr_ptr;
    logic [dmix_pkg::PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0]           count;

    // Storage, written on every push
    always_ff @(posedge clk245760) begin
        if (push_i) begin
            mem_left[wr_ptr]  <= push_left_i;
            mem_right[wr_ptr] <= push_right_i;
        end
    end

    always_ff @(posedge clk245760) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy
    always_ff @(posedge clk245760) begin
        if (rst) begin
            count <= '0;
        end else if (push_i && !pop_i) begin
            count <= count + 1'b1;
        end else if (pop_i && !push_i) begin
            count <= count - 1'b1;
        end
    end

    // One credit back per frame removed
    always_ff @(posedge clk245760) begin
        if (rst) begin
            credit_o <= 1'b0;
        end else begin
            credit_o <= pop_i;
        end
    end

    // Fall-through head
    assign empty_o      = (count == '0);
    assign head_left_o  = mem_left[rd_ptr];
    assign head_right_o = mem_right[rd_ptr];

    a_no_pop_empty: assert property (
        @(posedge clk245760) disable iff (rst)
        pop_i |-> !empty_o
    );

    // Producer credits must keep us from ever overfilling
    a_no_overfill: assert property (
        @(posedge clk245760) disable iff (rst)
        count <= CNT_W'(dmix_pkg::FIFO_DEPTH)
    );

endmodule

// File: dac/dac_i2s_drv.sv
`timescale 1ns/1ps

module dac_i2s_drv (
    input  logic              clk245760,
    input  logic              rst,

    input  logic              empty_i,
    input  dmix_pkg::sample_t head_left_i,
    input  dmix_pkg::sample_t head_right_i,
    output logic              pop_o,

    output logic              bck_o,
    output logic              lrck_o,
    output logic              data_o,

    output logic              underrun_o
);

    localparam int CNT_W   = $clog2(dmix_pkg::FRAME_CLKS);
    localparam int BCK_LSB = $clog2(dmix_pkg::BCK_DIV);
    localparam int SLOT_W  = $clog2(dmix_pkg::SLOT_BITS);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(dmix_pkg::FRAME_CLKS - 1);

    logic [CNT_W-1:0]  cnt;
    logic [CNT_W-1:0]  cnt_next;
    logic              frame_end;
    logic              slot_end;

    dmix_pkg::sample_t frame_left;
    dmix_pkg::sample_t frame_right;

    logic [SLOT_W-1:0] next_slot;
    logic              next_right;
    dmix_pkg::sample_t next_word;
    logic              next_bit;

    // Frame counter wraps once per I2S frame
    always_ff @(posedge clk245760) begin
        if (rst) begin
            cnt <= '0;
        end else begin
            cnt <= cnt_next;
        end
    end

    assign cnt_next  = cnt + 1'b1;
    assign frame_end = (cnt == LAST_CNT);
    assign slot_end  = (cnt[BCK_LSB-1:0] == '1);

    // Bit and word clocks straight off the counter
    assign bck_o  = cnt[BCK_LSB-1];
    assign lrck_o = cnt[CNT_W-1];

    assign pop_o = frame_end & ~empty_i;

    // Latch the head frame or zeros when the buffer ran dry
    always_ff @(posedge clk245760) begin
        if (rst) begin
            frame_left  <= '0;
            frame_right <= '0;
        end else if (frame_end) begin
            if (empty_i) begin
                frame_left  <= '0;
                frame_right <= '0;
            end else begin
                frame_left  <= head_left_i;
                frame_right <= head_right_i;
            end
        end
    end

    always_ff @(posedge clk245760) begin
        if (rst) begin
            underrun_o <= 1'b0;
        end else begin
            underrun_o <= frame_end & empty_i;
        end
    end

    // Slot about to start after the next falling bck edge
    assign next_slot  = cnt_next[BCK_LSB +: SLOT_W];
    assign next_right = cnt_next[CNT_W-1];
    assign next_word  = next_right ? frame_right : frame_left;

    // MSB goes out in slot 1, one bck after the lrck edge
    always_comb begin
        next_bit = 1'b0;
        if (next_slot >= SLOT_W'(1) && next_slot <= SLOT_W'(dmix_pkg::SAMPLE_W)) begin
            next_bit = next_word[dmix_pkg::SAMPLE_W - int'(next_slot)];
        end
    end

    // Data moves with the falling edge of bck
    always_ff @(posedge clk245760) begin
        if (rst) begin
            data_o <= 1'b0;
        end else if (slot_end) begin
            data_o <= next_bit;
        end
    end

endmodule

// File: logic/dmix_top.sv
`timescale 1ns/1ps

module dmix_top (
    input  logic              clk245760,
    input  logic              rst,

    // Receiver sample stream
    input  dmix_pkg::sample_t smp_data_i,
    input  logic              smp_lrck_i,
    input  logic              smp_ack_i,

    // I2S to DAC
    output logic              dac_bck_o,
    output logic              dac_lrck_o,
    output logic              dac_data_o,

    // Status pulses
    output logic              sync_err_o,
    output logic              overflow_o,
    output logic              underrun_o
);

    logic              push;
    dmix_pkg::sample_t push_left;
    dmix_pkg::sample_t push_right;
    logic              credit;

    logic              fifo_empty;
    dmix_pkg::sample_t head_left;
    dmix_pkg::sample_t head_right;
    logic              pop;

    dai_sample_pairer u_pairer (
        .clk245760    (clk245760),
        .rst          (rst),
        .smp_data_i   (smp_data_i),
        .smp_lrck_i   (smp_lrck_i),
        .smp_ack_i    (smp_ack_i),
        .credit_i     (credit),
        .push_o       (push),
        .push_left_o  (push_left),
        .push_right_o (push_right),
        .sync_err_o   (sync_err_o),
        .overflow_o   (overflow_o)
    );

    sample_fifo u_fifo (
        .clk245760    (clk245760),
        .rst          (rst),
        .push_i       (push),
        .push_left_i  (push_left),
        .push_right_i (push_right),
        .pop_i        (pop),
        .empty_o      (fifo_empty),
        .head_left_o  (head_left),
        .head_right_o (head_right),
        .credit_o     (credit)
    );

    dac_i2s_drv u_dac (
        .clk245760    (clk245760),
        .rst          (rst),
        .empty_i      (fifo_empty),
        .head_left_i  (head_left),
        .head_right_i (head_right),
        .pop_o        (pop),
        .bck_o        (dac_bck_o),
        .lrck_o       (dac_lrck_o),
        .data_o       (dac_data_o),
        .underrun_o   (underrun_o)
    );

endmodule

// File: dv/tb_dmix_checks.svh
`ifndef TB_DMIX_CHECKS_SVH
`define TB_DMIX_CHECKS_SVH

// Expected pairs in send order, and decoded frames that carried audio
dmix_pkg::sample_t model_left[$];
dmix_pkg::sample_t model_right[$];
dmix_pkg::sample_t got_left[$];
dmix_pkg::sample_t got_right[$];

int err_cnt  = 0;
int pass_cnt = 0;
int fail_cnt = 0;

task automatic compare_sample(input string name, input dmix_pkg::sample_t exp_val,
                              input dmix_pkg::sample_t act_val);
    if (act_val !== exp_val) begin
        $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp_val, act_val);
        err_cnt++;
    end
endtask

task automatic compare_count(input string name, input int exp_val, input int act_val);
    if (act_val != exp_val) begin
        $display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, exp_val, act_val);
        err_cnt++;
    end
endtask

task automatic compare_level(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
        $display("MISMATCH at %0t: %s expected %b got %b", $time, name, exp_val, act_val);
        err_cnt++;
    end
endtask

// In-order match; model pairs from skip_from on may be missing
task automatic check_frames(input int skip_from, input int overflow_seen);
    int idx;
    int skipped;
    idx = 0;
    skipped = 0;
    foreach (got_left[i]) begin
        while (idx >= skip_from && idx < model_left.size() &&
               (model_left[idx] != got_left[i] || model_right[idx] != got_right[i])) begin
            idx++;
            skipped++;
        end
        if (idx >= model_left.size()) begin
            $display("ERROR at %0t: played frame %0d matches no pair that was sent", $time, i);
            err_cnt++;
        end else begin
            compare_sample("dac_data_o left word", model_left[idx], got_left[i]);
            compare_sample("dac_data_o right word", model_right[idx], got_right[i]);
            idx++;
        end
    end
    compare_count("overflow_o pulses", skipped + model_left.size() - idx, overflow_seen);
endtask

task automatic clear_frames();
    model_left.delete();
    model_right.delete();
    got_left.delete();
    got_right.delete();
endtask

task automatic end_test(input string name, input int err_base);
    if (err_cnt == err_base) begin
        pass_cnt++;
        $display("test %s: passed", name);
    end else begin
        fail_cnt++;
        $display("test %s: failed with %0d errors", name, err_cnt - err_base);
    end
endtask

`endif

// File: dv/tb_dmix.sv
`timescale 1ns/1ps

module tb_dmix;

    // Reset, 120 frames of tests and a 10% margin
    localparam int RUN_LIMIT = 16 + (120 * dmix_pkg::FRAME_CLKS * 11) / 10;

    logic              clk245760;
    logic              rst;
    dmix_pkg::sample_t smp_data_i;
    logic              smp_lrck_i;
    logic              smp_ack_i;
    logic              dac_bck_o;
    logic              dac_lrck_o;
    logic              dac_data_o;
    logic              sync_err_o;
    logic              overflow_o;
    logic              underrun_o;

    int seed = 32'hae73;
    int cyc = 0;
    int sync_cnt = 0;
    int ovf_cnt = 0;
    int urun_cnt = 0;
    int frame_cnt = 0;
    int slot_idx = -1;
    logic prev_lrck = 1'b0;
    dmix_pkg::sample_t dec_left;
    dmix_pkg::sample_t dec_right;
    dmix_pkg::sample_t last_left;
    dmix_pkg::sample_t last_right;

    `include "tb_dmix_checks.svh"

    dmix_top u_dmix_top (
        .clk245760  (clk245760),
        .rst        (rst),
        .smp_data_i (smp_data_i),
        .smp_lrck_i (smp_lrck_i),
        .smp_ack_i  (smp_ack_i),
        .dac_bck_o  (dac_bck_o),
        .dac_lrck_o (dac_lrck_o),
        .dac_data_o (dac_data_o),
        .sync_err_o (sync_err_o),
        .overflow_o (overflow_o),
        .underrun_o (underrun_o)
    );

    initial begin
        clk245760 = 1'b0;
        forever #4 clk245760 = ~clk245760;
    end

    // Cycle count and status pulse counts
    always @(posedge clk245760) begin
        cyc      <= cyc + 1;
        sync_cnt <= sync_cnt + int'(sync_err_o);
        ovf_cnt  <= ovf_cnt + int'(overflow_o);
        urun_cnt <= urun_cnt + int'(underrun_o);
    end

    // I2S decoder, slot 0 follows each lrck edge
    always @(posedge dac_bck_o) begin
        if (dac_lrck_o != prev_lrck) begin
            slot_idx = 0;
        end else begin
            slot_idx = slot_idx + 1;
        end
        prev_lrck = dac_lrck_o;
        if (slot_idx >= 1 && slot_idx <= dmix_pkg::SAMPLE_W) begin
            if (dac_lrck_o) begin
                dec_right = {dec_right[dmix_pkg::SAMPLE_W-2:0], dac_data_o};
            end else begin
                dec_left = {dec_left[dmix_pkg::SAMPLE_W-2:0], dac_data_o};
            end
        end
        if (dac_lrck_o && slot_idx == dmix_pkg::SLOT_BITS - 1) begin
            last_left  = dec_left;
            last_right = dec_right;
            frame_cnt++;
            // All-zero frames are silence
            if (dec_left != '0 || dec_right != '0) begin
                got_left.push_back(dec_left);
                got_right.push_back(dec_right);
            end
        end
    end

    initial begin
        while (cyc < RUN_LIMIT) begin
            @(posedge clk245760);
        end
        $display("Timeout: tests still running after %0d cycles", cyc);
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic dmix_pkg::sample_t rand_sample();
        dmix_pkg::sample_t s;
        s = dmix_pkg::sample_t'($random(seed));
        if (s == '0) begin
            s = dmix_pkg::sample_t'(1);
        end
        return s;
    endfunction

    // One strobe followed by two idle cycles
    task automatic send_sample(input logic is_left, input dmix_pkg::sample_t value);
        @(posedge clk245760);
        smp_data_i <= value;
        smp_lrck_i <= is_left;
        smp_ack_i  <= 1'b1;
        @(posedge clk245760);
        smp_ack_i  <= 1'b0;
        @(posedge clk245760);
    endtask

    task automatic send_pair(input dmix_pkg::sample_t l_val, input dmix_pkg::sample_t r_val);
        send_sample(1'b1, l_val);
        send_sample(1'b0, r_val);
        model_left.push_back(l_val);
        model_right.push_back(r_val);
    endtask

    task automatic wait_frames(input int n);
        int stop_at;
        stop_at = frame_cnt + n;
        while (frame_cnt < stop_at) begin
            @(posedge clk245760);
        end
    endtask

    task automatic wait_played(input int n);
        while (got_left.size() < n) begin
            @(posedge clk245760);
        end
    endtask

    task automatic check_quiet(input logic in_reset);
        compare_level("sync_err_o", 1'b0, sync_err_o);
        compare_level("overflow_o", 1'b0, overflow_o);
        compare_level("underrun_o", 1'b0, underrun_o);
        compare_level("dac_data_o", 1'b0, dac_data_o);
        if (in_reset) begin
            compare_level("dac_bck_o", 1'b0, dac_bck_o);
            compare_level("dac_lrck_o", 1'b0, dac_lrck_o);
        end
    endtask

    initial begin
        int i;
        int target;
        int base_err;
        int base_ovf;
        int base_sync;
        int base_urun;
        int dup_idx;
        int orphan_idx;
        dmix_pkg::sample_t l_val;
        dmix_pkg::sample_t r_val;

        rst        = 1'b1;
        smp_data_i = '0;
        smp_lrck_i = 1'b0;
        smp_ack_i  = 1'b0;

        base_err = err_cnt;
        for (i = 0; i < 16; i++) begin
            @(posedge clk245760);
            if (i == 15) begin
                rst <= 1'b0;
            end
            if (i > 0) begin
                check_quiet(1'b1);
            end
        end
        while (frame_cnt == 0) begin
            @(posedge clk245760);
            check_quiet(1'b0);
        end
        compare_sample("first frame left word", '0, last_left);
        compare_sample("first frame right word", '0, last_right);
        end_test("reset", base_err);

        // Steady stream, one pair per frame period
        base_err  = err_cnt;
        base_ovf  = ovf_cnt;
        base_sync = sync_cnt;
        base_urun = urun_cnt;
        clear_frames();
        fork
            begin
                for (i = 0; i < 40; i++) begin
                    target = cyc + dmix_pkg::FRAME_CLKS;
                    l_val  = rand_sample();
                    r_val  = rand_sample();
                    send_pair(l_val, r_val);
                    while (cyc < target) begin
                        @(posedge clk245760);
                    end
                end
            end
            begin
                wait_played(1);
                base_urun = urun_cnt;
            end
        join
        wait_played(40);
        compare_count("underrun_o pulses", 0, urun_cnt - base_urun);
        compare_count("sync_err_o pulses", 0, sync_cnt - base_sync);
        check_frames(model_left.size(), ovf_cnt - base_ovf);
        end_test("steady stream", base_err);

        // Underrun, start on a frame boundary
        base_err = err_cnt;
        wait_frames(1);
        base_urun = urun_cnt;
        for (i = 0; i < 5; i++) begin
            wait_frames(1);
            compare_sample("silent frame left word", '0, last_left);
            compare_sample("silent frame right word", '0, last_right);
        end
        compare_count("underrun_o pulses", 5, urun_cnt - base_urun);
        end_test("underrun", base_err);

        // Burst of 12 pairs into an empty buffer
        base_err  = err_cnt;
        base_ovf  = ovf_cnt;
        base_sync = sync_cnt;
        clear_frames();
        for (i = 0; i < 12; i++) begin
            l_val = rand_sample();
            r_val = rand_sample();
            send_pair(l_val, r_val);
        end
        wait_played(dmix_pkg::FIFO_DEPTH);
        wait_frames(2);
        if (got_left.size() > dmix_pkg::FIFO_DEPTH + 1) begin
            $display("ERROR at %0t: %0d frames played from the burst, more than the buffer allows",
                     $time, got_left.size());
            err_cnt++;
        end
        compare_count("sync_err_o pulses", 0, sync_cnt - base_sync);
        check_frames(dmix_pkg::FIFO_DEPTH, ovf_cnt - base_ovf);
        end_test("overflow burst", base_err);

        // Duplicate left and orphan right in a paced stream
        base_err   = err_cnt;
        base_ovf   = ovf_cnt;
        base_sync  = sync_cnt;
        dup_idx    = int'({$random(seed)} % 10);
        orphan_idx = int'({$random(seed)} % 10);
        clear_frames();
        for (i = 0; i < 10; i++) begin
            target = cyc + dmix_pkg::FRAME_CLKS;
            if (i == orphan_idx) begin
                send_sample(1'b0, rand_sample());
            end
            if (i == dup_idx) begin
                send_sample(1'b1, rand_sample());
            end
            l_val = rand_sample();
            r_val = rand_sample();
            send_pair(l_val, r_val);
            while (cyc < target) begin
                @(posedge clk245760);
            end
        end
        wait_played(10);
        compare_count("sync_err_o pulses", 2, sync_cnt - base_sync);
        check_frames(model_left.size(), ovf_cnt - base_ovf);
        end_test("order errors", base_err);

        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+dv
common/dmix_pkg.sv
logic/dai_sample_pairer.sv
logic/sample_fifo.sv
dac/dac_i2s_drv.sv
logic/dmix_top.sv
dv/tb_dmix.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the dmix testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_dmix -f flist.f -o sim_dmix
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out="$(./obj_dir/sim_dmix 2>&1)"
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1
